// ==== verilog/calc_pkg.sv ====
package calc_pkg;

	// datapath widths
	localparam int DATA_W   = 32;	// operand and result width
	localparam int CMD_W    = 4;	// command code width
	localparam int RESP_W   = 2;	// response code width
	localparam int NUM_CHAN = 4;	// request channels sharing one execute unit
	localparam int CHAN_W   = 2;	// enough bits to name a channel
	localparam int SHAMT_W  = 5;	// shift amount bits taken from operand 2

	typedef logic [DATA_W-1:0] data_t;	// operand or result word
	typedef logic [CMD_W-1:0]  cmd_t;	// command code
	typedef logic [RESP_W-1:0] resp_t;	// response code
	typedef logic [CHAN_W-1:0] chan_t;	// channel index, 0 based

	// command codes, anything else is invalid
	localparam cmd_t CMD_NOP = 4'd0;	// nothing to do
	localparam cmd_t CMD_ADD = 4'd1;	// op1 + op2
	localparam cmd_t CMD_SUB = 4'd2;	// op1 - op2
	localparam cmd_t CMD_SHL = 4'd5;	// op1 << op2[4:0]
	localparam cmd_t CMD_SHR = 4'd6;	// op1 >> op2[4:0], logical

	// response codes
	localparam resp_t RESP_NONE = 2'd0;	// no response this cycle
	localparam resp_t RESP_OK   = 2'd1;	// data valid
	localparam resp_t RESP_ERR  = 2'd2;	// overflow or underflow
	localparam resp_t RESP_BAD  = 2'd3;	// invalid command

	// per-channel decode FSM
	typedef enum logic [1:0] {
		IDLE,		// waiting for a command strobe
		GET_OP2,	// next cycle carries operand 2
		PENDING		// request waits for the execute grant
	} dec_state_t;

endpackage

// ==== verilog/calc_decode.sv ====
module calc_decode (
	input  logic           c_clk,
	input  logic           arst_n,
	input  calc_pkg::cmd_t  req_cmd,	// one-cycle command strobe
	input  calc_pkg::data_t req_data,	// op1 with the strobe, op2 one cycle later
	input  logic           grant,	// execute has taken this request
	output logic           pend,	// complete request waiting
	output calc_pkg::cmd_t  pend_cmd,
	output calc_pkg::data_t pend_op1,
	output calc_pkg::data_t pend_op2
);

	calc_pkg::dec_state_t state;
	logic                 start;	// accepted command strobe

	// a command only counts in IDLE, no-ops never start anything
	assign start = (state == calc_pkg::IDLE) && (req_cmd != calc_pkg::CMD_NOP);

	always_ff @(posedge c_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= calc_pkg::IDLE;
		end else begin
			case (state)
				calc_pkg::IDLE: begin
					if (start) begin
						state <= calc_pkg::GET_OP2;	// op1 latched this edge
					end
				end
				calc_pkg::GET_OP2: begin
					state <= calc_pkg::PENDING;	// op2 latched this edge
				end
				calc_pkg::PENDING: begin
					if (grant) begin
						state <= calc_pkg::IDLE;	// execute took it, free the channel
					end
				end
				default: begin
					state <= calc_pkg::IDLE;
				end
			endcase
		end
	end

	// request payload, only meaningful while pend is high
	always_ff @(posedge c_clk) begin
		if (start) begin
			pend_cmd <= req_cmd;
			pend_op1 <= req_data;
		end
		if (state == calc_pkg::GET_OP2) begin
			pend_op2 <= req_data;
		end
	end

	assign pend = (state == calc_pkg::PENDING);	// high from E+1 until granted

endmodule

// ==== verilog/calc_execute.sv ====
module calc_execute (
	input  logic                          c_clk,
	input  logic                          arst_n,
	input  logic [calc_pkg::NUM_CHAN-1:0] pend,	// one bit per channel
	input  calc_pkg::cmd_t                pend_cmd [calc_pkg::NUM_CHAN],
	input  calc_pkg::data_t               pend_op1 [calc_pkg::NUM_CHAN],
	input  calc_pkg::data_t               pend_op2 [calc_pkg::NUM_CHAN],
	output logic [calc_pkg::NUM_CHAN-1:0] grant,	// lowest pending channel, one-hot
	output logic                          res_valid,
	output calc_pkg::chan_t               res_chan,
	output calc_pkg::resp_t               res_resp,
	output calc_pkg::data_t               res_data
);

	calc_pkg::chan_t                sel;	// granted channel index
	calc_pkg::cmd_t                 cmd;	// granted command
	calc_pkg::data_t                op1;
	calc_pkg::data_t                op2;
	logic [calc_pkg::SHAMT_W-1:0]   shamt;	// only the low bits of op2 shift
	logic [calc_pkg::DATA_W:0]      sum;	// carry in the top bit
	logic [calc_pkg::DATA_W:0]      diff;	// borrow in the top bit
	calc_pkg::resp_t                alu_resp;
	calc_pkg::data_t                alu_data;

	// fixed priority, walk down so the lowest pending channel wins
	always_comb begin
		grant = '0;
		sel   = '0;
		for (int i = calc_pkg::NUM_CHAN - 1; i >= 0; i--) begin
			if (pend[i]) begin
				grant    = '0;
				grant[i] = 1'b1;
				sel      = calc_pkg::chan_t'(i);
			end
		end
	end

	// operand mux from the granted channel
	assign cmd   = pend_cmd[sel];
	assign op1   = pend_op1[sel];
	assign op2   = pend_op2[sel];
	assign shamt = op2[calc_pkg::SHAMT_W-1:0];

	assign sum  = {1'b0, op1} + {1'b0, op2};
	assign diff = {1'b0, op1} - {1'b0, op2};	// top bit set when op2 > op1

	// result and error detect, data is zero unless the response is OK
	always_comb begin
		alu_resp = calc_pkg::RESP_BAD;
		alu_data = '0;
		case (cmd)
			calc_pkg::CMD_ADD: begin
				if (sum[calc_pkg::DATA_W]) begin
					alu_resp = calc_pkg::RESP_ERR;	// overflow
				end else begin
					alu_resp = calc_pkg::RESP_OK;
					alu_data = sum[calc_pkg::DATA_W-1:0];
				end
			end
			calc_pkg::CMD_SUB: begin
				if (diff[calc_pkg::DATA_W]) begin
					alu_resp = calc_pkg::RESP_ERR;	// underflow
				end else begin
					alu_resp = calc_pkg::RESP_OK;
					alu_data = diff[calc_pkg::DATA_W-1:0];
				end
			end
			calc_pkg::CMD_SHL: begin
				alu_resp = calc_pkg::RESP_OK;
				alu_data = op1 << shamt;
			end
			calc_pkg::CMD_SHR: begin
				alu_resp = calc_pkg::RESP_OK;
				alu_data = op1 >> shamt;	// logical, zero fill
			end
			default: begin
				alu_resp = calc_pkg::RESP_BAD;	// unknown code
				alu_data = '0;
			end
		endcase
	end

	// result register, one result per granted request
	always_ff @(posedge c_clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
			res_resp  <= calc_pkg::RESP_NONE;
		end else begin
			res_valid <= |grant;
			res_resp  <= (|grant) ? alu_resp : calc_pkg::RESP_NONE;
		end
	end

	always_ff @(posedge c_clk) begin
		res_chan <= sel;	// only read while res_valid is high
		res_data <= alu_data;
	end

endmodule

// ==== verilog/calc_result.sv ====
module calc_result (
	input  logic            c_clk,
	input  logic            arst_n,
	input  logic            res_valid,	// one result from execute
	input  calc_pkg::chan_t res_chan,	// channel it belongs to
	input  calc_pkg::resp_t res_resp,
	input  calc_pkg::data_t res_data,
	output calc_pkg::resp_t out1_resp,
	output calc_pkg::resp_t out2_resp,
	output calc_pkg::resp_t out3_resp,
	output calc_pkg::resp_t out4_resp,
	output calc_pkg::data_t out1_data,
	output calc_pkg::data_t out2_data,
	output calc_pkg::data_t out3_data,
	output calc_pkg::data_t out4_data
);

	calc_pkg::resp_t resp_q [calc_pkg::NUM_CHAN];	// per-channel output registers
	calc_pkg::data_t data_q [calc_pkg::NUM_CHAN];

	// every channel falls back to idle each cycle, only the target gets the pulse
	always_ff @(posedge c_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < calc_pkg::NUM_CHAN; i++) begin
				resp_q[i] <= calc_pkg::RESP_NONE;
				data_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < calc_pkg::NUM_CHAN; i++) begin
				if (res_valid && (res_chan == calc_pkg::chan_t'(i))) begin
					resp_q[i] <= res_resp;
					data_q[i] <= res_data;
				end else begin
					resp_q[i] <= calc_pkg::RESP_NONE;	// pulse lasts one cycle
					data_q[i] <= '0;
				end
			end
		end
	end

	// channel n maps to index n-1
	assign out1_resp = resp_q[0];
	assign out2_resp = resp_q[1];
	assign out3_resp = resp_q[2];
	assign out4_resp = resp_q[3];
	assign out1_data = data_q[0];
	assign out2_data = data_q[1];
	assign out3_data = data_q[2];
	assign out4_data = data_q[3];

endmodule

// ==== verilog/calc_top.sv ====
module calc_top (
	input  logic            c_clk,
	input  logic            arst_n,
	input  calc_pkg::cmd_t  req1_cmd,
	input  calc_pkg::cmd_t  req2_cmd,
	input  calc_pkg::cmd_t  req3_cmd,
	input  calc_pkg::cmd_t  req4_cmd,
	input  calc_pkg::data_t req1_data,
	input  calc_pkg::data_t req2_data,
	input  calc_pkg::data_t req3_data,
	input  calc_pkg::data_t req4_data,
	output calc_pkg::resp_t out1_resp,
	output calc_pkg::resp_t out2_resp,
	output calc_pkg::resp_t out3_resp,
	output calc_pkg::resp_t out4_resp,
	output calc_pkg::data_t out1_data,
	output calc_pkg::data_t out2_data,
	output calc_pkg::data_t out3_data,
	output calc_pkg::data_t out4_data
);

	calc_pkg::cmd_t                req_cmd  [calc_pkg::NUM_CHAN];	// inputs as arrays
	calc_pkg::data_t               req_data [calc_pkg::NUM_CHAN];
	logic [calc_pkg::NUM_CHAN-1:0] pend;
	logic [calc_pkg::NUM_CHAN-1:0] grant;
	calc_pkg::cmd_t                pend_cmd [calc_pkg::NUM_CHAN];
	calc_pkg::data_t               pend_op1 [calc_pkg::NUM_CHAN];
	calc_pkg::data_t               pend_op2 [calc_pkg::NUM_CHAN];
	logic                          res_valid;
	calc_pkg::chan_t               res_chan;
	calc_pkg::resp_t               res_resp;
	calc_pkg::data_t               res_data;

	assign req_cmd[0]  = req1_cmd;
	assign req_cmd[1]  = req2_cmd;
	assign req_cmd[2]  = req3_cmd;
	assign req_cmd[3]  = req4_cmd;
	assign req_data[0] = req1_data;
	assign req_data[1] = req2_data;
	assign req_data[2] = req3_data;
	assign req_data[3] = req4_data;

	// one decoder per channel
	for (genvar n = 0; n < calc_pkg::NUM_CHAN; n++) begin : g_dec
		calc_decode u_decode (
			.c_clk    (c_clk),
			.arst_n   (arst_n),
			.req_cmd  (req_cmd[n]),
			.req_data (req_data[n]),
			.grant    (grant[n]),
			.pend     (pend[n]),
			.pend_cmd (pend_cmd[n]),
			.pend_op1 (pend_op1[n]),
			.pend_op2 (pend_op2[n])
		);
	end

	calc_execute u_execute (	// shared by all channels
		.c_clk     (c_clk),
		.arst_n    (arst_n),
		.pend      (pend),
		.pend_cmd  (pend_cmd),
		.pend_op1  (pend_op1),
		.pend_op2  (pend_op2),
		.grant     (grant),
		.res_valid (res_valid),
		.res_chan  (res_chan),
		.res_resp  (res_resp),
		.res_data  (res_data)
	);

	calc_result u_result (
		.c_clk     (c_clk),
		.arst_n    (arst_n),
		.res_valid (res_valid),
		.res_chan  (res_chan),
		.res_resp  (res_resp),
		.res_data  (res_data),
		.out1_resp (out1_resp),
		.out2_resp (out2_resp),
		.out3_resp (out3_resp),
		.out4_resp (out4_resp),
		.out1_data (out1_data),
		.out2_data (out2_data),
		.out3_data (out3_data),
		.out4_data (out4_data)
	);

endmodule

// ==== sim/calc_asserts.sv ====
module calc_asserts (
	input logic                          c_clk,
	input logic                          arst_n,
	input logic [calc_pkg::NUM_CHAN-1:0] pend,
	input logic [calc_pkg::NUM_CHAN-1:0] grant,
	input logic                          res_valid
);

	// at most one channel wins the execute unit
	a_grant_onehot: assert property (@(posedge c_clk) disable iff (!arst_n)
		$onehot0(grant))
		else $error("grant is not zero or one-hot: %b", grant);

	// a grant only goes to a channel that asked
	a_grant_pending: assert property (@(posedge c_clk) disable iff (!arst_n)
		((grant & ~pend) == '0))
		else $error("grant %b given without pend %b", grant, pend);

	// result register follows the grant by one cycle
	a_valid_after_grant: assert property (@(posedge c_clk) disable iff (!arst_n)
		(res_valid == $past(|grant)))
		else $error("res_valid %b does not follow last cycle's grant", res_valid);

endmodule

bind calc_execute calc_asserts u_asserts (
	.c_clk     (c_clk),
	.arst_n    (arst_n),
	.pend      (pend),
	.grant     (grant),
	.res_valid (res_valid)
);

// ==== sim/calc_tb_vectors.svh ====
`ifndef CALC_TB_VECTORS_SVH
`define CALC_TB_VECTORS_SVH

typedef struct packed {
	calc_pkg::chan_t chan;	// 0 based, channel n+1 on the ports
	calc_pkg::cmd_t  cmd;
	calc_pkg::data_t op1;	// sent with the strobe
	calc_pkg::data_t op2;	// sent one cycle later
	calc_pkg::resp_t resp;	// expected response
	calc_pkg::data_t data;	// expected data
} vector_t;

vector_t vectors [32];
int      num_vectors = 0;

task automatic add_vector(input int chan, input calc_pkg::cmd_t cmd, input calc_pkg::data_t op1,
		input calc_pkg::data_t op2, input calc_pkg::resp_t resp, input calc_pkg::data_t data);
	vectors[num_vectors] = {chan[1:0], cmd, op1, op2, resp, data};
	num_vectors++;
endtask

// columns: channel, command, operand 1, operand 2, expected response, expected data
task automatic load_vectors();
	add_vector(0, calc_pkg::CMD_ADD, 32'h5, 32'h7, calc_pkg::RESP_OK, 32'hc);
	add_vector(1, calc_pkg::CMD_ADD, 32'hffffffff, 32'h1, calc_pkg::RESP_ERR, 32'h0);	// wraps by 1
	add_vector(2, calc_pkg::CMD_ADD, 32'hf0f0f0f0, 32'h0f0f0f0f, calc_pkg::RESP_OK, 32'hffffffff);
	add_vector(3, calc_pkg::CMD_ADD, 32'h0, 32'h0, calc_pkg::RESP_OK, 32'h0);
	add_vector(0, calc_pkg::CMD_SUB, 32'h9, 32'h4, calc_pkg::RESP_OK, 32'h5);
	add_vector(1, calc_pkg::CMD_SUB, 32'h1234, 32'h1234, calc_pkg::RESP_OK, 32'h0);	// equal
	add_vector(2, calc_pkg::CMD_SUB, 32'h4, 32'h5, calc_pkg::RESP_ERR, 32'h0);	// under by 1
	add_vector(3, calc_pkg::CMD_SUB, 32'hffffffff, 32'h1, calc_pkg::RESP_OK, 32'hfffffffe);
	add_vector(0, calc_pkg::CMD_SHL, 32'h1, 32'd31, calc_pkg::RESP_OK, 32'h80000000);
	add_vector(1, calc_pkg::CMD_SHL, 32'ha5a5a5a5, 32'd0, calc_pkg::RESP_OK, 32'ha5a5a5a5);
	add_vector(2, calc_pkg::CMD_SHL, 32'h3, 32'd33, calc_pkg::RESP_OK, 32'h6);	// acts as 1
	add_vector(3, calc_pkg::CMD_SHL, 32'hffffffff, 32'd32, calc_pkg::RESP_OK, 32'hffffffff);
	add_vector(0, calc_pkg::CMD_SHR, 32'h80000000, 32'd31, calc_pkg::RESP_OK, 32'h1);
	add_vector(1, calc_pkg::CMD_SHR, 32'h12345678, 32'd0, calc_pkg::RESP_OK, 32'h12345678);
	add_vector(2, calc_pkg::CMD_SHR, 32'h80000000, 32'd33, calc_pkg::RESP_OK, 32'h40000000);
	add_vector(3, calc_pkg::CMD_SHR, 32'hdeadbeef, 32'd32, calc_pkg::RESP_OK, 32'hdeadbeef);
	add_vector(0, 4'd3, 32'h1, 32'h1, calc_pkg::RESP_BAD, 32'h0);	// unused codes
	add_vector(1, 4'd4, 32'h2, 32'h3, calc_pkg::RESP_BAD, 32'h0);
	add_vector(2, 4'd7, 32'hffffffff, 32'h1, calc_pkg::RESP_BAD, 32'h0);
	add_vector(3, 4'd15, 32'h8, 32'h2, calc_pkg::RESP_BAD, 32'h0);
endtask

// reference model, returns {resp, data}
function automatic logic [33:0] expected_result(input calc_pkg::cmd_t cmd,
		input calc_pkg::data_t a, input calc_pkg::data_t b);
	int unsigned amt;
	amt = b % 32;	// only five bits of the amount count
	case (cmd)
		calc_pkg::CMD_ADD: begin
			if (a > 32'hffffffff - b)
				expected_result = {calc_pkg::RESP_ERR, 32'h0};	// sum does not fit
			else
				expected_result = {calc_pkg::RESP_OK, a + b};
		end
		calc_pkg::CMD_SUB: begin
			if (b > a)
				expected_result = {calc_pkg::RESP_ERR, 32'h0};
			else
				expected_result = {calc_pkg::RESP_OK, a - b};
		end
		calc_pkg::CMD_SHL: expected_result = {calc_pkg::RESP_OK, a << amt};
		calc_pkg::CMD_SHR: expected_result = {calc_pkg::RESP_OK, a >> amt};
		default: expected_result = {calc_pkg::RESP_BAD, 32'h0};
	endcase
endfunction

`endif

// ==== sim/calc_tb.sv ====
module calc_tb;

	localparam int RAND_SEED   = 61;
	localparam int WAIT_CYCLES = 12;	// response timeout in cycles
	localparam int ROUNDS      = 10;	// concurrent rounds

	logic            c_clk;
	logic            arst_n;
	calc_pkg::cmd_t  req_cmd  [calc_pkg::NUM_CHAN];	// index n drives channel n+1
	calc_pkg::data_t req_data [calc_pkg::NUM_CHAN];
	calc_pkg::resp_t out1_resp;
	calc_pkg::resp_t out2_resp;
	calc_pkg::resp_t out3_resp;
	calc_pkg::resp_t out4_resp;
	calc_pkg::data_t out1_data;
	calc_pkg::data_t out2_data;
	calc_pkg::data_t out3_data;
	calc_pkg::data_t out4_data;
	calc_pkg::resp_t out_resp [calc_pkg::NUM_CHAN];
	calc_pkg::data_t out_data [calc_pkg::NUM_CHAN];
	int              errors;
	int              errs_before;	// error count when a test starts
	int              tests_run;
	int              tests_failed;
	int              seed_val;
	int unsigned     seed_ret;

	`include "calc_tb_vectors.svh"

	calc_top dut (
		.c_clk (c_clk), .arst_n (arst_n),
		.req1_cmd (req_cmd[0]), .req2_cmd (req_cmd[1]),
		.req3_cmd (req_cmd[2]), .req4_cmd (req_cmd[3]),
		.req1_data (req_data[0]), .req2_data (req_data[1]),
		.req3_data (req_data[2]), .req4_data (req_data[3]),
		.out1_resp (out1_resp), .out2_resp (out2_resp),
		.out3_resp (out3_resp), .out4_resp (out4_resp),
		.out1_data (out1_data), .out2_data (out2_data),
		.out3_data (out3_data), .out4_data (out4_data)
	);

	assign out_resp[0] = out1_resp;	// index n mirrors channel n+1
	assign out_resp[1] = out2_resp;
	assign out_resp[2] = out3_resp;
	assign out_resp[3] = out4_resp;
	assign out_data[0] = out1_data;
	assign out_data[1] = out2_data;
	assign out_data[2] = out3_data;
	assign out_data[3] = out4_data;

	initial begin
		c_clk = 1'b0;
		forever #20 c_clk = ~c_clk;	// period 40
	end

	task automatic compare(input string sig, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is 'h%0h, expected 'h%0h", $time, sig, got, exp);
			errors++;
		end
	endtask

	// channel k shows no response and zero data
	task automatic expect_quiet(input int k);
		compare($sformatf("out%0d_resp", k + 1), out_resp[k], calc_pkg::RESP_NONE);
		compare($sformatf("out%0d_data", k + 1), out_data[k], 32'h0);
	endtask

	task automatic check_idle();
		for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
			expect_quiet(k);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED", tests_run, name);
		end
	endtask

	function automatic calc_pkg::cmd_t random_cmd(input int unsigned r);
		case (r % 10)
			0, 1: random_cmd = calc_pkg::CMD_ADD;
			2, 3: random_cmd = calc_pkg::CMD_SUB;
			4, 5: random_cmd = calc_pkg::CMD_SHL;
			6, 7: random_cmd = calc_pkg::CMD_SHR;
			8: random_cmd = 4'd3;	// an invalid code now and then
			default: random_cmd = 4'd9;
		endcase
	endfunction

	// one command on one channel with its pulse due at the 4th falling edge after E
	task automatic run_vector(input vector_t v);
		int ch;
		int cyc;
		bit found;
		ch = v.chan;
		@(negedge c_clk);
		req_cmd[ch]  = v.cmd;	// strobe sampled at edge E
		req_data[ch] = v.op1;
		@(negedge c_clk);
		req_cmd[ch]  = calc_pkg::CMD_NOP;
		req_data[ch] = v.op2;	// sampled at E+1
		cyc   = 1;
		found = 1'b0;
		while (!found && cyc <= WAIT_CYCLES) begin
			@(negedge c_clk);
			cyc++;
			req_data[ch] = '0;
			for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
				if (k != ch) begin
					expect_quiet(k);	// unused channels stay silent
				end
			end
			if (out_resp[ch] != calc_pkg::RESP_NONE)
				found = 1'b1;
		end
		if (!found) begin
			$display("timeout: out%0d gave no response to command %0d", ch + 1, v.cmd);
			errors++;
		end else begin
			compare($sformatf("out%0d_resp", ch + 1), out_resp[ch], v.resp);
			compare($sformatf("out%0d_data", ch + 1), out_data[ch], v.data);
			compare($sformatf("out%0d latency", ch + 1), cyc, 4);
			@(negedge c_clk);
			expect_quiet(ch);	// pulse is over
		end
	endtask

	task automatic run_nop(input int ch);
		int cyc;
		@(negedge c_clk);
		req_cmd[ch]  = calc_pkg::CMD_NOP;
		req_data[ch] = 32'h1234_5678;	// data without a strobe
		@(negedge c_clk);
		req_data[ch] = 32'h0000_0003;
		cyc = 0;
		while (cyc < WAIT_CYCLES) begin
			@(negedge c_clk);
			cyc++;
			req_data[ch] = '0;
			check_idle();
		end
	endtask

	// all four channels strobe at the same edge and channel k answers k cycles late
	task automatic run_round();
		calc_pkg::cmd_t  cmd  [calc_pkg::NUM_CHAN];
		calc_pkg::data_t op1  [calc_pkg::NUM_CHAN];
		calc_pkg::data_t op2  [calc_pkg::NUM_CHAN];
		logic [33:0]     exp  [calc_pkg::NUM_CHAN];
		int              hits [calc_pkg::NUM_CHAN];
		int              cyc;
		for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
			cmd[k]  = random_cmd($urandom);
			op1[k]  = $urandom;
			op2[k]  = $urandom;
			exp[k]  = expected_result(cmd[k], op1[k], op2[k]);
			hits[k] = 0;
		end
		@(negedge c_clk);
		for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
			req_cmd[k]  = cmd[k];
			req_data[k] = op1[k];
		end
		@(negedge c_clk);
		for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
			req_cmd[k]  = calc_pkg::CMD_NOP;
			req_data[k] = op2[k];
		end
		cyc = 1;
		while (cyc <= WAIT_CYCLES) begin
			@(negedge c_clk);
			cyc++;
			for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
				req_data[k] = '0;
				if (out_resp[k] != calc_pkg::RESP_NONE) begin
					hits[k]++;
					compare($sformatf("out%0d_resp", k + 1), out_resp[k], exp[k][33:32]);
					compare($sformatf("out%0d_data", k + 1), out_data[k], exp[k][31:0]);
					compare($sformatf("out%0d latency", k + 1), cyc, 4 + k);
				end else begin
					compare($sformatf("out%0d_data", k + 1), out_data[k], 32'h0);
				end
			end
		end
		for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
			if (hits[k] != 1) begin
				$display("out%0d gave %0d response pulses, expected exactly 1", k + 1, hits[k]);
				errors++;
			end
		end
	endtask

	initial begin
		arst_n = 1'b0;
		for (int k = 0; k < calc_pkg::NUM_CHAN; k++) begin
			req_cmd[k]  = calc_pkg::CMD_NOP;
			req_data[k] = '0;
		end
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		seed_val     = RAND_SEED;
		seed_ret     = $urandom(seed_val);	// seeds the generator once
		load_vectors();

		errs_before = errors;
		repeat (10) begin
			@(negedge c_clk);
			check_idle();	// outputs quiet while in reset
		end
		arst_n = 1'b1;
		repeat (2) begin
			@(negedge c_clk);
			check_idle();
		end
		finish_test("reset");

		for (int i = 0; i < num_vectors; i++) begin
			errs_before = errors;
			run_vector(vectors[i]);
			finish_test($sformatf("cmd %0d on channel %0d", vectors[i].cmd, vectors[i].chan + 1));
		end

		for (int ch = 0; ch < calc_pkg::NUM_CHAN; ch++) begin
			errs_before = errors;
			run_nop(ch);
			finish_test($sformatf("no-op on channel %0d", ch + 1));
		end

		for (int r = 0; r < ROUNDS; r++) begin
			errs_before = errors;
			run_round();
			finish_test($sformatf("concurrent round %0d", r));
		end

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+sim
verilog/calc_pkg.sv
verilog/calc_decode.sv
verilog/calc_execute.sv
verilog/calc_result.sv
verilog/calc_top.sv
sim/calc_asserts.sv
sim/calc_tb.sv

// ==== Bender.yml ====
package:
  name: calc

sources:
  - verilog/calc_pkg.sv
  - verilog/calc_decode.sv
  - verilog/calc_execute.sv
  - verilog/calc_result.sv
  - verilog/calc_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/calc_asserts.sv
      - sim/calc_tb.sv
